// ==== bench/flexka_checks.svh ====
`ifndef FLEXKA_CHECKS_SVH
`define FLEXKA_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic check_word(input string name, input word_t got, input word_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_state(input string name, input state_e got, input state_e exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_cycles(input string name, input cycle_t got, input cycle_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

`endif

// ==== bench/tb_flexka.sv ====
`timescale 1ns/100ps
`include "flexka_config.svh"

module tb_flexka;
  import flexka_pkg::*;

  localparam int WB = `FLEXKA_WORD_BITS;
  localparam int IN_D = `FLEXKA_IN_DEPTH;
  localparam int OUT_D = `FLEXKA_OUT_DEPTH;
  localparam int N_TESTS = 7;
  localparam int TIMEOUT_CYCLES = N_TESTS * (OUT_D + 2 * IN_D * IN_D + IN_D + 40) * 2;

  typedef struct packed {
    logic [3:0]         na;
    logic [3:0]         nb;
    logic               rnd;    // Words come from the LFSR
    logic [WB*IN_D-1:0] a;
    logic [WB*IN_D-1:0] b;
    cycle_t             cycles; // CLEAR + per row (2 per column + flush)
  } test_entry_t;

  logic        clk;
  logic        rstn;
  logic        cmd_valid;
  command_e    cmd;
  word_t       cmd_data;
  state_e      flexka_state;
  word_t       out_data;
  cycle_t      elapsed_cycles;
  test_entry_t tests [N_TESTS];
  cycle_t      seen_cycles [IN_D+1][IN_D+1];
  logic [15:0] lfsr_state;
  int          cycle_count;
  int          errs;

  `include "flexka_checks.svh"

  flexka uut (
    .clk            (clk),
    .rstn           (rstn),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .cmd_data       (cmd_data),
    .flexka_state   (flexka_state),
    .out_data       (out_data),
    .elapsed_cycles (elapsed_cycles)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic rand_word(output word_t w);
    for (int k = 0; k < WB; k++) begin
      w = {w[WB-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic send_cmd(input command_e c, input word_t d);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    cmd_data  <= d;
  endtask

  task automatic release_cmd;
    @(posedge clk);
    cmd_valid <= 1'b0;
    cmd       <= NONE;
  endtask

  // Read data shows on the third edge after the strobe
  task automatic read_word(input out_addr_t addr, output word_t w);
    send_cmd(OUTADDR, word_t'(addr));
    release_cmd;
    repeat (2) @(posedge clk);
    @(negedge clk);
    w = out_data;
  endtask

  task automatic wait_run_done;
    @(negedge clk);
    while (flexka_state == IDLE) @(negedge clk);
    while (flexka_state != IDLE) @(negedge clk);
  endtask

  task automatic run_test(input int t);
    logic [WB*IN_D-1:0]   a_val;
    logic [WB*IN_D-1:0]   b_val;
    logic [2*WB*IN_D-1:0] prod;
    word_t                w;
    cycle_t               cyc;
    int                   na;
    int                   nb;
    errs  = error_count;
    na    = int'(tests[t].na);
    nb    = int'(tests[t].nb);
    a_val = tests[t].a;
    b_val = tests[t].b;
    for (int k = 0; k < IN_D; k++) begin
      if (tests[t].rnd && k < na) rand_word(a_val[k*WB +: WB]);
      if (k >= na) a_val[k*WB +: WB] = '0;
    end
    for (int k = 0; k < IN_D; k++) begin
      if (tests[t].rnd && k < nb) rand_word(b_val[k*WB +: WB]);
      if (k >= nb) b_val[k*WB +: WB] = '0;
    end
    prod = {{WB*IN_D{1'b0}}, a_val} * {{WB*IN_D{1'b0}}, b_val};
    send_cmd(SIZE_A, word_t'(na));
    for (int k = 0; k < na; k++) send_cmd(DATA_A, a_val[k*WB +: WB]);
    send_cmd(SIZE_B, word_t'(nb));
    for (int k = 0; k < nb; k++) send_cmd(DATA_B, b_val[k*WB +: WB]);
    send_cmd(START, '0);
    release_cmd;
    wait_run_done;
    cyc = elapsed_cycles;
    check_cycles("elapsed_cycles", cyc, tests[t].cycles);
    if (seen_cycles[na][nb] != 0) check_cycles("elapsed_cycles", cyc, seen_cycles[na][nb]);
    seen_cycles[na][nb] = cyc;
    for (int k = 0; k < OUT_D; k++) begin
      read_word(out_addr_t'(k), w);
      check_word($sformatf("out_data[%0d]", k), w, prod[k*WB +: WB]);
    end
    check_cycles("elapsed_cycles", elapsed_cycles, cyc); // Holds while idle
    $display("test %0d (%0dx%0d words): %0d mismatches", t, na, nb, error_count - errs);
  endtask

  initial begin
    rstn       = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = NONE;
    cmd_data   = '0;
    lfsr_state = 16'd98;
    for (int x = 0; x <= IN_D; x++) begin
      for (int y = 0; y <= IN_D; y++) seen_cycles[x][y] = '0;
    end
    tests[0] = '{4'd1, 4'd1, 1'b0, 128'hffff, 128'hffff, 32'd19};
    tests[1] = '{4'd1, 4'd1, 1'b0, 128'h1234, 128'h5678, 32'd19};
    tests[2] = '{4'd8, 4'd8, 1'b1, 128'h0, 128'h0, 32'd152};
    tests[3] = '{4'd3, 4'd5, 1'b0, 128'h8001_abcd_ffff, 128'h7fff_0000_ffff_1357_2468, 32'd49};
    tests[4] = '{4'd2, 4'd6, 1'b1, 128'h0, 128'h0, 32'd42};
    tests[5] = '{4'd3, 4'd5, 1'b1, 128'h0, 128'h0, 32'd49};
    tests[6] = '{4'd8, 4'd1, 1'b0, {8{16'hffff}}, 128'hfffe, 32'd40};
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_state("flexka_state", flexka_state, IDLE);
    check_cycles("elapsed_cycles", elapsed_cycles, '0);
    $display("reset: %0d mismatches", error_count);
    for (int t = 0; t < N_TESTS; t++) run_test(t);
    $display("%0d tests, %0d checks, %0d errors", N_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== flexka_base.f ====
+incdir+rtl
+incdir+bench
rtl/flexka_pkg.sv
rtl/flexka_mac_if.sv
rtl/flexka_control.sv
rtl/flexka_loop_counter.sv
rtl/flexka_operand_buffers.sv
rtl/flexka_product_accumulator.sv
rtl/flexka.sv
bench/tb_flexka.sv

// ==== rtl/flexka.sv ====
`timescale 1ns/100ps

module flexka (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 cmd_valid,
  input  flexka_pkg::command_e cmd,
  input  flexka_pkg::word_t    cmd_data,
  output flexka_pkg::state_e   flexka_state,
  output flexka_pkg::word_t    out_data,
  output flexka_pkg::cycle_t   elapsed_cycles
);
  import flexka_pkg::*;

  word_t    cmd_word;
  logic     load_a;
  logic     load_b;
  logic     size_a_set;
  logic     size_b_set;
  logic     out_addr_set;
  in_addr_t size_a;
  in_addr_t size_b;
  word_t    a_word;
  word_t    b_word;

  flexka_mac_if mac ();

  flexka_control u_control (
    .clk          (clk),
    .rstn         (rstn),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .cmd_data     (cmd_data),
    .state        (flexka_state),
    .cmd_word     (cmd_word),
    .load_a       (load_a),
    .load_b       (load_b),
    .size_a_set   (size_a_set),
    .size_b_set   (size_b_set),
    .out_addr_set (out_addr_set),
    .mac          (mac.control)
  );

  flexka_loop_counter u_counter (
    .clk            (clk),
    .rstn           (rstn),
    .state          (flexka_state),
    .size_a         (size_a),
    .size_b         (size_b),
    .elapsed_cycles (elapsed_cycles),
    .mac            (mac.counter)
  );

  flexka_operand_buffers u_operands (
    .clk        (clk),
    .rstn       (rstn),
    .load_a     (load_a),
    .load_b     (load_b),
    .size_a_set (size_a_set),
    .size_b_set (size_b_set),
    .cmd_data   (cmd_word),
    .size_a     (size_a),
    .size_b     (size_b),
    .a_word     (a_word),
    .b_word     (b_word),
    .mac        (mac.datapath)
  );

  flexka_product_accumulator u_product (
    .clk          (clk),
    .rstn         (rstn),
    .out_addr_set (out_addr_set),
    .cmd_data     (cmd_word),
    .a_word       (a_word),
    .b_word       (b_word),
    .size_b       (size_b),
    .out_data     (out_data),
    .mac          (mac.datapath)
  );

endmodule

// ==== rtl/flexka_config.svh ====
`ifndef FLEXKA_CONFIG_SVH
`define FLEXKA_CONFIG_SVH

// Operand and result word width
`define FLEXKA_WORD_BITS 16

`define FLEXKA_IN_DEPTH  8
// Full product needs twice the input depth
`define FLEXKA_OUT_DEPTH 16

`endif

// ==== rtl/flexka_control.sv ====
`timescale 1ns/100ps
`include "flexka_config.svh"

module flexka_control (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 cmd_valid,
  input  flexka_pkg::command_e cmd,
  input  flexka_pkg::word_t    cmd_data,
  output flexka_pkg::state_e   state,
  output flexka_pkg::word_t    cmd_word,
  output logic                 load_a,
  output logic                 load_b,
  output logic                 size_a_set,
  output logic                 size_b_set,
  output logic                 out_addr_set,
  flexka_mac_if.control        mac
);
  import flexka_pkg::*;

  command_e cmd_q;
  state_e   state_next;
  logic     busy;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cmd_q <= NONE;
      state <= IDLE;
    end else begin
      cmd_q <= cmd_valid ? cmd : NONE;
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      cmd_word <= cmd_data;
    end
  end

  assign busy = (state != IDLE);

  // Loads are dropped while a run is in progress
  assign size_a_set   = (cmd_q == SIZE_A) && !busy;
  assign size_b_set   = (cmd_q == SIZE_B) && !busy;
  assign load_a       = (cmd_q == DATA_A) && !busy;
  assign load_b       = (cmd_q == DATA_B) && !busy;
  assign out_addr_set = (cmd_q == OUTADDR); // Allowed any time

  assign mac.clear_en = (state == CLEAR);
  assign mac.mac_en   = (state == MULTIPLY);
  assign mac.flush_en = (state == FLUSH);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (cmd_q == START) begin
          state_next = CLEAR;
        end
      end
      CLEAR: begin
        if (mac.clear_addr == out_addr_t'(`FLEXKA_OUT_DEPTH - 1)) begin
          state_next = MULTIPLY;
        end
      end
      MULTIPLY: begin
        if (mac.row_done) begin
          state_next = FLUSH;
        end
      end
      FLUSH: state_next = mac.last_row ? IDLE : MULTIPLY; // One flush per row
      default: state_next = IDLE;
    endcase
  end

endmodule

// ==== rtl/flexka_loop_counter.sv ====
`timescale 1ns/100ps

module flexka_loop_counter (
  input  logic                clk,
  input  logic                rstn,
  input  flexka_pkg::state_e  state,
  input  flexka_pkg::in_addr_t size_a,
  input  flexka_pkg::in_addr_t size_b,
  output flexka_pkg::cycle_t  elapsed_cycles,
  flexka_mac_if.counter       mac
);
  import flexka_pkg::*;

  // Write half of the last column in the row
  assign mac.row_done = (state == MULTIPLY) && mac.wr_phase &&
                        (in_addr_t'(mac.j + 1'b1) == size_b);
  assign mac.last_row = (in_addr_t'(mac.i + 1'b1) == size_a);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mac.i          <= '0;
      mac.j          <= '0;
      mac.wr_phase   <= 1'b0;
      mac.clear_addr <= '0;
    end else begin
      mac.clear_addr <= (state == CLEAR) ? mac.clear_addr + 1'b1 : '0;
      case (state)
        MULTIPLY: begin
          mac.wr_phase <= ~mac.wr_phase;
          if (mac.wr_phase) begin
            mac.j <= mac.row_done ? '0 : mac.j + 1'b1;
          end
        end
        FLUSH: begin
          mac.i        <= mac.i + 1'b1;
          mac.wr_phase <= 1'b0;
        end
        default: begin
          mac.i        <= '0;
          mac.j        <= '0;
          mac.wr_phase <= 1'b0;
        end
      endcase
    end
  end

  // First CLEAR cycle restarts the count
  always_ff @(posedge clk) begin
    if (!rstn) begin
      elapsed_cycles <= '0;
    end else if (state == CLEAR && mac.clear_addr == '0) begin
      elapsed_cycles <= 32'd1;
    end else if (state != IDLE) begin
      elapsed_cycles <= elapsed_cycles + 1'b1;
    end
  end

endmodule

// ==== rtl/flexka_mac_if.sv ====
`timescale 1ns/100ps

interface flexka_mac_if;
  import flexka_pkg::*;

  in_addr_t  i;           // Row index into A
  in_addr_t  j;           // Column index into B
  out_addr_t clear_addr;
  logic      wr_phase;    // Second half of a column step
  logic      clear_en;
  logic      mac_en;
  logic      flush_en;
  logic      row_done;
  logic      last_row;

  modport control (output clear_en, mac_en, flush_en,
                   input row_done, last_row, clear_addr);

  modport counter (output i, j, clear_addr, wr_phase, row_done, last_row);

  modport datapath (input i, j, clear_addr, wr_phase, clear_en, mac_en, flush_en);

endinterface

// ==== rtl/flexka_operand_buffers.sv ====
`timescale 1ns/100ps
`include "flexka_config.svh"

module flexka_operand_buffers (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 load_a,
  input  logic                 load_b,
  input  logic                 size_a_set,
  input  logic                 size_b_set,
  input  flexka_pkg::word_t    cmd_data,
  output flexka_pkg::in_addr_t size_a,
  output flexka_pkg::in_addr_t size_b,
  output flexka_pkg::word_t    a_word,
  output flexka_pkg::word_t    b_word,
  flexka_mac_if.datapath       mac
);
  import flexka_pkg::*;

  localparam int IN_AW = $clog2(`FLEXKA_IN_DEPTH);

  // Index 0 is buffer A, index 1 is buffer B
  word_t            mem [2][`FLEXKA_IN_DEPTH];
  logic [IN_AW-1:0] load_addr [2];
  in_addr_t         size [2];
  logic [1:0]       load;
  logic [1:0]       set;

  assign load   = {load_b, load_a};
  assign set    = {size_b_set, size_a_set};
  assign size_a = size[0];
  assign size_b = size[1];

  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      if (!rstn) begin
        size[k]      <= '0;
        load_addr[k] <= '0;
      end else if (set[k]) begin
        size[k]      <= in_addr_t'(cmd_data);
        load_addr[k] <= '0; // Rewind for the next data words
      end else if (load[k]) begin
        load_addr[k] <= load_addr[k] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      if (load[k]) begin
        mem[k][load_addr[k]] <= cmd_data;
      end
    end
    a_word <= mem[0][mac.i[IN_AW-1:0]];
    b_word <= mem[1][mac.j[IN_AW-1:0]];
  end

endmodule

// ==== rtl/flexka_pkg.sv ====
`include "flexka_config.svh"

package flexka_pkg;

  typedef logic [`FLEXKA_WORD_BITS-1:0] word_t;

  // One extra bit so a full size of IN_DEPTH fits
  typedef logic [$clog2(`FLEXKA_IN_DEPTH):0] in_addr_t;

  typedef logic [$clog2(`FLEXKA_OUT_DEPTH)-1:0] out_addr_t;

  typedef logic [31:0] cycle_t;

  typedef enum logic [2:0] {
    NONE    = 3'd0,
    SIZE_A  = 3'd1,
    SIZE_B  = 3'd2,
    DATA_A  = 3'd3,
    DATA_B  = 3'd4,
    OUTADDR = 3'd5,
    START   = 3'd6
  } command_e;

  typedef enum logic [1:0] {
    IDLE, CLEAR, MULTIPLY, FLUSH
  } state_e;

endpackage

// ==== rtl/flexka_product_accumulator.sv ====
`timescale 1ns/100ps
`include "flexka_config.svh"

module flexka_product_accumulator (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 out_addr_set,
  input  flexka_pkg::word_t    cmd_data,
  input  flexka_pkg::word_t    a_word,
  input  flexka_pkg::word_t    b_word,
  input  flexka_pkg::in_addr_t size_b,
  output flexka_pkg::word_t    out_data,
  flexka_mac_if.datapath       mac
);
  import flexka_pkg::*;

  localparam int W = `FLEXKA_WORD_BITS;

  word_t            mem_c [`FLEXKA_OUT_DEPTH];
  out_addr_t        out_addr;   // Software read address
  out_addr_t        mac_addr;
  out_addr_t        flush_addr;
  out_addr_t        rd_addr;
  word_t            c_rd;
  word_t            carry;
  logic [2*W-1:0]   sum;
  logic             mac_wr;

  assign mac_addr   = out_addr_t'(mac.i + mac.j);
  assign flush_addr = out_addr_t'(mac.i + size_b);
  assign mac_wr     = mac.mac_en && mac.wr_phase;

  // MAC owns the read port while multiplying
  assign rd_addr = mac.mac_en ? mac_addr : out_addr;

  // Never overflows two words
  assign sum = a_word * b_word + c_rd + carry;

  assign out_data = c_rd;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_addr <= '0;
    end else if (out_addr_set) begin
      out_addr <= out_addr_t'(cmd_data);
    end
  end

  always_ff @(posedge clk) begin
    if (mac.clear_en) begin
      mem_c[mac.clear_addr] <= '0;
    end else if (mac_wr) begin
      mem_c[mac_addr] <= sum[W-1:0];
    end else if (mac.flush_en) begin
      mem_c[flush_addr] <= carry; // Top word of the row
    end
    c_rd <= mem_c[rd_addr];
  end

  always_ff @(posedge clk) begin
    if (mac.clear_en || mac.flush_en) begin
      carry <= '0;
    end else if (mac_wr) begin
      carry <= sum[2*W-1:W];
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the flexka testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_flexka \
  -f flexka_base.f -Mdir obj_dir -o tb_flexka
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_flexka > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  exit 0
fi
exit 1
